// ==== Makefile ====
# Verilator build and run of the debug module testbench

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_debug_module -Mdir obj_dir
	out=$$(./obj_dir/Vtb_debug_module); echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== src.f ====
+incdir+verilog
verilog/dm_pkg.sv
verilog/dm_ctrl_if.sv
verilog/dm_regs.sv
verilog/dm_run_ctrl.sv
verilog/debug_module.sv
verif/tb_debug_module.sv

// ==== verif/tb_debug_module.sv ====
// testbench for the debug module: host register sequences against a simple core model
// expected register values come from a model of the writes the test has made
`timescale 1ns/1ns
`include "dm_consts.svh"

module tb_debug_module;

   localparam int NUM_TESTS = 6;

   logic clk, rst, dmi_en, dmi_wr;
   logic [`DM_ADDR_W-1:0] dmi_addr;
   logic [31:0] dmi_wdata, dmi_rdata, dbg_cmd_wrdata, core_rddata;
   logic dbg_halt_req, dbg_resume_req, dbg_core_rst, dbg_cmd_valid, dbg_cmd_write, dbg_cmd_gpr;
   logic [11:0] dbg_cmd_addr;
   logic core_halted, core_resume_ack, core_cmd_done, core_cmd_fail;

   // host side record of what the registers should hold
   logic [31:0] m_ctrl, m_command, m_data0;
   logic m_havereset, m_halted, m_resumeack;
   logic [2:0] m_cmderr;
   // core model
   logic [31:0] core_regs [0:4095];
   logic [31:0] rnd_state, exp_wrdata;
   logic [11:0] exp_addr, cur_addr;
   logic exp_write, exp_gpr, cur_write, force_fail, resume_pend;
   int done_cnt, halt_cnt, cmd_count, errors, test_errors, test_num;
   // read comparison pipeline
   logic cmp_req, cmp_stage;
   logic [31:0] cmp_exp, cmp_exp_s;
   logic [6:0] cmp_addr, cmp_addr_s;

   debug_module debug_module_i (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      #((NUM_TESTS * 200 + 8) * 100);
      $display("watchdog: the tests did not finish in the allowed time");
      $display("Errors found");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // expected read value of a debug register
   function automatic logic [31:0] expected_read(input logic [6:0] addr);
      case (addr)
         `DM_DATA0:      return m_data0;
         `DM_DMCONTROL:  return m_ctrl;
         `DM_DMSTATUS:   return {12'b0, {2{m_havereset}}, {2{m_resumeack}}, 6'b0,
                                 {2{m_halted}}, 1'b1, 3'b0, `DM_VERSION};
         `DM_ABSTRACTCS: return {21'b0, m_cmderr, 4'b0, `DM_DATACOUNT};
         `DM_COMMAND:    return m_command;
         `DM_HALTSUM0:   return {31'b0, m_halted};
         default:        return 32'b0;
      endcase
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
      if (exp !== got) begin
         $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp, got);
         errors++;
      end
   endtask

   always @(posedge clk) begin
      cmp_stage  <= cmp_req;
      cmp_exp_s  <= cmp_exp;
      cmp_addr_s <= cmp_addr;
   end

   always @(negedge clk) begin
      if (cmp_stage) begin
         check_val($sformatf("dmi_rdata[reg %h]", cmp_addr_s), cmp_exp_s, dmi_rdata);
      end
   end

   //*********************************************************************
   // core model
   //*********************************************************************
   always @(negedge clk) begin
      core_cmd_done   = 1'b0;
      core_resume_ack = 1'b0;
      if (done_cnt != 0) begin
         done_cnt--;
         if (done_cnt == 0) begin
            core_cmd_done = 1'b1;
            core_cmd_fail = force_fail;
            core_rddata   = cur_write ? 32'b0 : core_regs[cur_addr];
            if (cur_write && !force_fail) core_regs[cur_addr] = exp_wrdata;
         end
      end
      if (dbg_cmd_valid) begin
         check_val("dbg_cmd_addr", {20'b0, exp_addr}, {20'b0, dbg_cmd_addr});
         check_val("dbg_cmd_write", {31'b0, exp_write}, {31'b0, dbg_cmd_write});
         check_val("dbg_cmd_gpr", {31'b0, exp_gpr}, {31'b0, dbg_cmd_gpr});
         if (exp_write) check_val("dbg_cmd_wrdata", exp_wrdata, dbg_cmd_wrdata);
         cur_addr  = dbg_cmd_addr;
         cur_write = dbg_cmd_write;
         rnd_state = xorshift(rnd_state);
         done_cnt  = 1 + int'(rnd_state % 4);
         cmd_count++;
      end
      if (resume_pend) begin
         check_val("dbg_resume_req", 32'h0, {31'b0, dbg_resume_req});   // one cycle pulse
         core_resume_ack = 1'b1;
         core_halted     = 1'b0;   // running again
         resume_pend     = 1'b0;
      end
      if (dbg_resume_req) resume_pend = 1'b1;
      if (halt_cnt != 0) begin
         halt_cnt--;
         if (halt_cnt == 0) core_halted = 1'b1;
      end else if (dbg_halt_req && !core_halted) begin
         halt_cnt = 3;
      end
   end

   //*********************************************************************
   // host access tasks, all start and end on a falling edge
   //*********************************************************************
   task automatic reg_write(input logic [6:0] addr, input logic [31:0] data);
      dmi_en = 1'b1;
      dmi_wr = 1'b1;
      dmi_addr = addr;
      dmi_wdata = data;
      @(negedge clk);
      dmi_en = 1'b0;
      dmi_wr = 1'b0;
   endtask

   task automatic reg_read(input logic [6:0] addr, output logic [31:0] data);
      dmi_en = 1'b1;
      dmi_addr = addr;
      @(negedge clk);
      dmi_en = 1'b0;
      data = dmi_rdata;
   endtask

   task automatic check_read(input logic [6:0] addr);
      logic [31:0] d;
      cmp_req  = 1'b1;
      cmp_exp  = expected_read(addr);
      cmp_addr = addr;
      reg_read(addr, d);
      cmp_req = 1'b0;
   endtask

   task automatic poll(input logic [6:0] addr, input logic [31:0] mask, input logic [31:0] val);
      logic [31:0] d;
      reg_read(addr, d);
      while ((d & mask) != val) reg_read(addr, d);
   endtask

   task automatic write_ctrl(input logic [31:0] data);
      m_ctrl = data & 32'hd000_0003;
      if (data[`DMC_ACKHAVERESET]) m_havereset = 1'b0;
      else if (data[`DMC_NDMRESET]) m_havereset = 1'b1;
      reg_write(`DM_DMCONTROL, data);
   endtask

   // GPR command write with the cmderr rules for a busy-free host
   task automatic run_command(input logic [7:0] cmdtype, input logic write,
                              input logic [11:0] regno);
      logic [31:0] cmd;
      cmd        = {cmdtype, 7'b0, write, `CMD_GPR_BANK, regno};
      exp_addr   = regno;
      exp_write  = write;
      exp_gpr    = 1'b1;
      exp_wrdata = m_data0;
      if (cmdtype != `CMD_ACCESS_REG) m_cmderr = 3'd2;
      else if (!m_halted) m_cmderr = 3'd4;
      if (m_halted) m_command = cmd;
      reg_write(`DM_COMMAND, cmd);
      poll(`DM_ABSTRACTCS, 32'h1 << `ABS_BUSY_BIT, 32'h0);
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %0d errors", test_num, name, errors - test_errors);
      test_num++;
      test_errors = errors;
   endtask

   initial begin
      rst = 1'b1;
      {dmi_en, dmi_wr, dmi_addr, dmi_wdata} = '0;
      {core_halted, core_resume_ack, core_cmd_done, core_cmd_fail, core_rddata} = '0;
      {m_ctrl, m_command, m_data0, m_havereset, m_halted, m_resumeack, m_cmderr} = '0;
      {cmp_req, cmp_exp, cmp_addr, force_fail, resume_pend} = '0;
      {exp_addr, exp_write, exp_gpr, exp_wrdata, cur_addr, cur_write} = '0;
      {done_cnt, halt_cnt, cmd_count, errors, test_errors} = '0;
      test_num  = 1;
      rnd_state = 32'd61;
      for (int i = 0; i < 4096; i++) core_regs[i] = 32'h5a00_0000 ^ (i * 32'h0001_0003);
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      write_ctrl(32'h1);
      check_read(`DM_DMSTATUS);
      check_read(`DM_DMCONTROL);
      check_read(`DM_ABSTRACTCS);
      check_read(`DM_HALTSUM0);
      end_test("reset");

      write_ctrl(32'h8000_0001);
      poll(`DM_DMSTATUS, 32'h300, 32'h300);
      check_val("dbg_halt_req", 32'h0, {31'b0, dbg_halt_req});   // no longer idle
      m_halted = 1'b1;
      check_read(`DM_DMSTATUS);
      check_read(`DM_HALTSUM0);
      end_test("halt");

      m_data0 = 32'hcafe_1234;
      reg_write(`DM_DATA0, m_data0);
      run_command(8'd0, 1'b1, 12'd5);   // write gpr 5
      if (cmd_count != 1) begin
         $display("the core did not see the write command");
         errors++;
      end
      check_read(`DM_ABSTRACTCS);
      m_data0 = 32'h0;
      reg_write(`DM_DATA0, m_data0);
      run_command(8'd0, 1'b0, 12'd5);   // read it back
      m_data0 = 32'hcafe_1234;
      check_read(`DM_DATA0);
      check_read(`DM_ABSTRACTCS);
      end_test("abstract access");

      run_command(8'd2, 1'b0, 12'd0);   // cmdtype 2
      if (cmd_count != 2) begin
         $display("a command with an unsupported type reached the core");
         errors++;
      end
      check_read(`DM_ABSTRACTCS);
      m_cmderr = 3'd0;
      reg_write(`DM_ABSTRACTCS, 32'h700);
      check_read(`DM_ABSTRACTCS);
      force_fail = 1'b1;
      run_command(8'd0, 1'b0, 12'd3);
      m_cmderr = 3'd3;
      check_read(`DM_ABSTRACTCS);
      check_read(`DM_DATA0);
      force_fail = 1'b0;
      m_cmderr = 3'd0;
      reg_write(`DM_ABSTRACTCS, 32'h700);
      check_read(`DM_ABSTRACTCS);
      end_test("command errors");

      write_ctrl(32'h4000_0001);
      poll(`DM_DMSTATUS, 32'h3_0300, 32'h3_0000);
      m_halted = 1'b0;
      m_resumeack = 1'b1;
      check_read(`DM_DMSTATUS);
      write_ctrl(32'h1);
      m_resumeack = 1'b0;
      @(negedge clk);   // resumeack follows resumereq a cycle later
      check_read(`DM_DMSTATUS);
      run_command(8'd0, 1'b0, 12'd5);   // hart is running now
      check_read(`DM_ABSTRACTCS);
      check_read(`DM_COMMAND);
      m_cmderr = 3'd0;
      reg_write(`DM_ABSTRACTCS, 32'h700);
      check_read(`DM_ABSTRACTCS);
      end_test("resume");

      write_ctrl(32'h3);
      check_val("dbg_core_rst", 32'h1, {31'b0, dbg_core_rst});
      check_read(`DM_DMSTATUS);
      write_ctrl(32'h1000_0001);
      check_val("dbg_core_rst", 32'h0, {31'b0, dbg_core_rst});
      check_read(`DM_DMSTATUS);
      check_read(`DM_DMCONTROL);
      end_test("ndmreset");

      repeat (2) @(negedge clk);
      $display("%0d tests, %0d errors", test_num - 1, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// ==== verilog/debug_module.sv ====
// debug module top: host register port and core run-control port
// joins the register block and the run-control FSM
`timescale 1ns/1ns
`include "dm_consts.svh"

module debug_module (
   input  logic                  clk,
   input  logic                  rst,
   // host register port
   input  logic                  dmi_en,
   input  logic                  dmi_wr,
   input  logic [`DM_ADDR_W-1:0] dmi_addr,
   input  logic [`DM_DATA_W-1:0] dmi_wdata,
   output logic [`DM_DATA_W-1:0] dmi_rdata,
   // core side
   output logic                  dbg_halt_req,
   output logic                  dbg_resume_req,
   output logic                  dbg_core_rst,
   output logic                  dbg_cmd_valid,
   output logic                  dbg_cmd_write,
   output logic                  dbg_cmd_gpr,
   output logic [11:0]           dbg_cmd_addr,
   output logic [`DM_DATA_W-1:0] dbg_cmd_wrdata,
   input  logic                  core_halted,
   input  logic                  core_resume_ack,
   input  logic                  core_cmd_done,
   input  logic                  core_cmd_fail,
   input  logic [`DM_DATA_W-1:0] core_rddata
);

   dm_ctrl_if ctrl_if ();

   dm_regs regs_i (
      .clk            (clk),
      .rst            (rst),
      .dmi_en         (dmi_en),
      .dmi_wr         (dmi_wr),
      .dmi_addr       (dmi_addr),
      .dmi_wdata      (dmi_wdata),
      .dmi_rdata      (dmi_rdata),
      .core_cmd_fail  (core_cmd_fail),
      .core_rddata    (core_rddata),
      .dbg_core_rst   (dbg_core_rst),
      .dbg_cmd_write  (dbg_cmd_write),
      .dbg_cmd_gpr    (dbg_cmd_gpr),
      .dbg_cmd_addr   (dbg_cmd_addr),
      .dbg_cmd_wrdata (dbg_cmd_wrdata),
      .ctrl           (ctrl_if)
   );

   dm_run_ctrl run_ctrl_i (
      .clk             (clk),
      .rst             (rst),
      .core_halted     (core_halted),
      .core_resume_ack (core_resume_ack),
      .core_cmd_done   (core_cmd_done),
      .dbg_halt_req    (dbg_halt_req),
      .dbg_resume_req  (dbg_resume_req),
      .dbg_cmd_valid   (dbg_cmd_valid),
      .ctrl            (ctrl_if)
   );

endmodule

// ==== verilog/dm_consts.svh ====
// register numbers and field positions of the debug module
// included by the RTL and the testbench
`ifndef DM_CONSTS_SVH
`define DM_CONSTS_SVH

`define DM_ADDR_W         7
`define DM_DATA_W         32

// debug register numbers
`define DM_DATA0          7'h04
`define DM_DMCONTROL      7'h10
`define DM_DMSTATUS       7'h11
`define DM_ABSTRACTCS     7'h16
`define DM_COMMAND        7'h17
`define DM_HALTSUM0       7'h40

// dmcontrol bits
`define DMC_HALTREQ       31
`define DMC_RESUMEREQ     30
`define DMC_ACKHAVERESET  28
`define DMC_NDMRESET      1
`define DMC_DMACTIVE      0

`define DM_VERSION        4'd2   // dmstatus[3:0]
`define DM_DATACOUNT      4'd1   // abstractcs[3:0]
`define ABS_BUSY_BIT      12
`define ABS_CMDERR_LSB    8

// command fields
`define CMD_ACCESS_REG    8'd0   // cmdtype, command[31:24]
`define CMD_WRITE_BIT     16
`define CMD_GPR_BANK      4'd1   // command[15:12]

`endif

// ==== verilog/dm_ctrl_if.sv ====
// link between the debug register block and the run-control FSM
// regs side holds the host controls, run side reports state back
`timescale 1ns/1ns

interface dm_ctrl_if;

   // from the register block
   logic haltreq;
   logic resumereq;
   logic ndmreset;
   logic ctrl_written;        // dmcontrol written last cycle
   logic cmd_written;         // accepted command write, this cycle
   logic cmd_err_set;

   // from run control
   dm_pkg::dm_state_t state;
   logic halted;
   logic busy;
   logic resumeack;
   logic cmd_complete;

   modport regs (
      output haltreq, resumereq, ndmreset, ctrl_written, cmd_written, cmd_err_set,
      input  state, halted, busy, resumeack, cmd_complete
   );

   modport run (
      input  haltreq, resumereq, ndmreset, ctrl_written, cmd_written, cmd_err_set,
      output state, halted, busy, resumeack, cmd_complete
   );

endinterface

// ==== verilog/dm_pkg.sv ====
// types shared by the debug module blocks and the interface between them
package dm_pkg;

   // run-control FSM
   typedef enum logic [2:0] {
      idle      = 3'd0,
      halting   = 3'd1,
      halted    = 3'd2,
      cmd_start = 3'd3,
      cmd_wait  = 3'd4,
      cmd_done  = 3'd5,
      resuming  = 3'd6
   } dm_state_t;

   // abstractcs.cmderr codes
   typedef enum logic [2:0] {
      none          = 3'd0,
      busy          = 3'd1,
      not_supported = 3'd2,
      exception     = 3'd3,
      halt_resume   = 3'd4   // command while the hart was running
   } cmd_err_t;

endpackage

// ==== verilog/dm_regs.sv ====
// host visible debug registers: dmcontrol, dmstatus, abstractcs, command,
// data0 and haltsum0, with cmderr tracking and the command fields to the core
`timescale 1ns/1ns
`include "dm_consts.svh"

module dm_regs (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dmi_en,
   input  logic                  dmi_wr,
   input  logic [`DM_ADDR_W-1:0] dmi_addr,
   input  logic [`DM_DATA_W-1:0] dmi_wdata,
   output logic [`DM_DATA_W-1:0] dmi_rdata,
   input  logic                  core_cmd_fail,
   input  logic [`DM_DATA_W-1:0] core_rddata,
   output logic                  dbg_core_rst,
   output logic                  dbg_cmd_write,
   output logic                  dbg_cmd_gpr,
   output logic [11:0]           dbg_cmd_addr,
   output logic [`DM_DATA_W-1:0] dbg_cmd_wrdata,
   dm_ctrl_if.regs               ctrl
);

   logic                  dm_rst;
   logic                  dmactive;
   logic                  ackhavereset;
   logic                  havereset;
   logic [`DM_DATA_W-1:0] command;
   logic [`DM_DATA_W-1:0] data0;
   dm_pkg::cmd_err_t      cmderr;
   dm_pkg::cmd_err_t      cmderr_nxt;
   logic                  host_wr;
   logic                  ctrl_wren;
   logic                  cmd_wren;
   logic                  abs_wren;
   logic                  data0_wren;
   logic                  data0_load;
   logic                  is_halted;
   logic [`DM_DATA_W-1:0] dmcontrol;
   logic [`DM_DATA_W-1:0] dmstatus;
   logic [`DM_DATA_W-1:0] abstractcs;
   logic [`DM_DATA_W-1:0] rdata_nxt;

   assign dm_rst    = rst | ~dmactive;
   assign host_wr   = dmi_en & dmi_wr;
   assign ctrl_wren = host_wr & (dmi_addr == `DM_DMCONTROL);
   assign cmd_wren  = host_wr & (dmi_addr == `DM_COMMAND);
   assign abs_wren  = host_wr & (dmi_addr == `DM_ABSTRACTCS);
   assign is_halted = (ctrl.state == dm_pkg::halted);

   //*********************************************************************
   // dmcontrol and havereset
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         dmactive <= 1'b0;      // only the system reset clears it
      end else if (ctrl_wren) begin
         dmactive <= dmi_wdata[`DMC_DMACTIVE];
      end
   end

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         ctrl.haltreq      <= 1'b0;
         ctrl.resumereq    <= 1'b0;
         ackhavereset      <= 1'b0;
         ctrl.ndmreset     <= 1'b0;
         ctrl.ctrl_written <= 1'b0;
      end else begin
         ctrl.ctrl_written <= ctrl_wren;
         if (ctrl_wren) begin
            ctrl.haltreq   <= dmi_wdata[`DMC_HALTREQ];
            ctrl.resumereq <= dmi_wdata[`DMC_RESUMEREQ];
            ackhavereset   <= dmi_wdata[`DMC_ACKHAVERESET];
            ctrl.ndmreset  <= dmi_wdata[`DMC_NDMRESET];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         havereset <= 1'b0;
      end else if (ctrl_wren & dmi_wdata[`DMC_ACKHAVERESET]) begin
         havereset <= 1'b0;     // ack wins over a new ndmreset
      end else if (ctrl_wren & dmi_wdata[`DMC_NDMRESET]) begin
         havereset <= 1'b1;
      end
   end

   assign dbg_core_rst = ctrl.ndmreset;

   //*********************************************************************
   // abstract command, data0 and cmderr
   //*********************************************************************
   assign ctrl.cmd_written = cmd_wren & is_halted;
   assign data0_wren       = host_wr & (dmi_addr == `DM_DATA0) & is_halted;
   assign data0_load       = ctrl.cmd_complete & ~command[`CMD_WRITE_BIT] & ~core_cmd_fail;

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         command <= '0;
         data0   <= '0;
      end else begin
         if (ctrl.cmd_written) begin
            command <= dmi_wdata;
         end
         if (data0_load) begin
            data0 <= core_rddata;   // read result from the core
         end else if (data0_wren) begin
            data0 <= dmi_wdata;
         end
      end
   end

   always_comb begin
      cmderr_nxt = cmderr;
      if (ctrl.busy & dmi_en & ((dmi_wr & (dmi_addr == `DM_ABSTRACTCS ||
          dmi_addr == `DM_COMMAND)) | (dmi_addr == `DM_DATA0))) begin
         cmderr_nxt = dm_pkg::busy;
      end else if (cmd_wren & (dmi_wdata[31:24] != `CMD_ACCESS_REG)) begin
         cmderr_nxt = dm_pkg::not_supported;
      end else if (ctrl.cmd_complete & core_cmd_fail) begin
         cmderr_nxt = dm_pkg::exception;
      end else if (cmd_wren & ~is_halted) begin
         cmderr_nxt = dm_pkg::halt_resume;
      end else if (abs_wren) begin
         // write one to clear
         cmderr_nxt = dm_pkg::cmd_err_t'(cmderr & ~dmi_wdata[`ABS_CMDERR_LSB +: 3]);
      end
   end

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         cmderr <= dm_pkg::none;
      end else begin
         cmderr <= cmderr_nxt;
      end
   end

   assign ctrl.cmd_err_set = (cmderr != dm_pkg::none);

   //*********************************************************************
   // read port
   //*********************************************************************
   assign dmcontrol  = {ctrl.haltreq, ctrl.resumereq, 1'b0, ackhavereset, 26'b0,
                        ctrl.ndmreset, dmactive};
   assign dmstatus   = {12'b0, {2{havereset}}, {2{ctrl.resumeack}}, 6'b0,
                        {2{ctrl.halted}}, 1'b1, 3'b0, `DM_VERSION};   // bit 7 authenticated
   assign abstractcs = {19'b0, ctrl.busy, 1'b0, cmderr, 4'b0, `DM_DATACOUNT};

   always_comb begin
      case (dmi_addr)
         `DM_DATA0:      rdata_nxt = data0;
         `DM_DMCONTROL:  rdata_nxt = dmcontrol;
         `DM_DMSTATUS:   rdata_nxt = dmstatus;
         `DM_ABSTRACTCS: rdata_nxt = abstractcs;
         `DM_COMMAND:    rdata_nxt = command;
         `DM_HALTSUM0:   rdata_nxt = {31'b0, ctrl.halted};
         default:        rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (dm_rst) begin
         dmi_rdata <= '0;
      end else if (dmi_en) begin
         dmi_rdata <= rdata_nxt;
      end
   end

   // fields to the core
   assign dbg_cmd_write  = command[`CMD_WRITE_BIT];
   assign dbg_cmd_gpr    = (command[15:12] == `CMD_GPR_BANK);
   assign dbg_cmd_addr   = command[11:0];
   assign dbg_cmd_wrdata = data0;

   // the core sees one regno for the whole command
   a_cmd_addr_stable: assert property (@(posedge clk) disable iff (dm_rst)
      ctrl.busy |=> $stable(dbg_cmd_addr));

endmodule

// ==== verilog/dm_run_ctrl.sv ====
// halt, resume and abstract command sequencing toward the core
// steps on the host controls coming from the register block
`timescale 1ns/1ns

module dm_run_ctrl (
   input  logic    clk,
   input  logic    rst,
   input  logic    core_halted,
   input  logic    core_resume_ack,
   input  logic    core_cmd_done,
   output logic    dbg_halt_req,
   output logic    dbg_resume_req,
   output logic    dbg_cmd_valid,
   dm_ctrl_if.run  ctrl
);

   dm_pkg::dm_state_t next_state;
   logic              start_cmd;
   logic              start_resume;

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.halted <= 1'b0;
      end else begin
         ctrl.halted <= core_halted;
      end
   end

   //*********************************************************************
   // FSM
   //*********************************************************************
   always_comb begin
      next_state = ctrl.state;
      case (ctrl.state)
         dm_pkg::idle: begin
            if ((ctrl.haltreq | ctrl.halted) & ~ctrl.ndmreset) begin
               next_state = ctrl.halted ? dm_pkg::halted : dm_pkg::halting;
            end
         end
         dm_pkg::halting: begin
            if (ctrl.halted) begin
               next_state = dm_pkg::halted;
            end
         end
         dm_pkg::halted: begin
            if (~ctrl.halted | ctrl.ndmreset) begin
               next_state = ctrl.haltreq ? dm_pkg::halting : dm_pkg::idle;
            end else if (ctrl.cmd_written) begin
               next_state = dm_pkg::cmd_start;
            end else if (ctrl.ctrl_written & ctrl.resumereq & ~ctrl.haltreq) begin
               next_state = dm_pkg::resuming;
            end
         end
         dm_pkg::cmd_start: begin
            // pending error skips the core
            next_state = ctrl.cmd_err_set ? dm_pkg::cmd_done : dm_pkg::cmd_wait;
         end
         dm_pkg::cmd_wait: begin
            if (core_cmd_done) begin
               next_state = dm_pkg::cmd_done;
            end
         end
         dm_pkg::cmd_done: next_state = dm_pkg::halted;
         dm_pkg::resuming: begin
            if (ctrl.resumeack) begin
               next_state = dm_pkg::idle;
            end
         end
         default: next_state = dm_pkg::idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.state <= dm_pkg::idle;
      end else begin
         ctrl.state <= next_state;
      end
   end

   assign start_cmd    = (ctrl.state == dm_pkg::halted) & (next_state == dm_pkg::cmd_start);
   assign start_resume = (ctrl.state == dm_pkg::halted) & (next_state == dm_pkg::resuming);

   //*********************************************************************
   // busy and resumeack
   //*********************************************************************
   always_ff @(posedge clk) begin
      if (rst) begin
         ctrl.busy      <= 1'b0;
         ctrl.resumeack <= 1'b0;
      end else begin
         if (start_cmd) begin
            ctrl.busy <= 1'b1;
         end else if (ctrl.state == dm_pkg::cmd_done) begin
            ctrl.busy <= 1'b0;
         end
         if ((ctrl.state == dm_pkg::resuming) & core_resume_ack) begin
            ctrl.resumeack <= 1'b1;
         end else if (~ctrl.resumereq) begin
            ctrl.resumeack <= 1'b0;   // host dropped resumereq
         end
      end
   end

   assign ctrl.cmd_complete = (ctrl.state == dm_pkg::cmd_wait) & core_cmd_done;

   // core side
   assign dbg_halt_req   = ctrl.haltreq & ((ctrl.state == dm_pkg::idle) | ctrl.ctrl_written);
   assign dbg_resume_req = start_resume;                 // one cycle
   assign dbg_cmd_valid  = (ctrl.state == dm_pkg::cmd_start) & ~ctrl.cmd_err_set;

   a_ack_not_halted: assert property (@(posedge clk) disable iff (rst)
      !(core_resume_ack && core_halted));

   // the core answers only the command in flight
   a_done_in_wait: assert property (@(posedge clk) disable iff (rst)
      core_cmd_done |-> (ctrl.state == dm_pkg::cmd_wait));

endmodule
